/* flist.f */
verilog/uart_pkg.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/uart_channel.sv
verilog/uart_bus_decode.sv
verilog/uart_read_collect.sv
verilog/uart_subsystem.sv
verification/uart_subsystem_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS = --binary --timing -j 0 -Wno-fatal
TOP = uart_subsystem_tb
FLIST = flist.f
BUILD_DIR = obj_dir
LOG = sim.log
FAIL_MSG = Simulation failed
PASS_MSG = Simulation completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "test failed, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "no result found in $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verification/uart_subsystem_tb.sv */
`timescale 1ns/1ps

module uart_subsystem_tb;
    import uart_pkg::*;

    localparam int SEED = 32'hff4b;
    localparam int TX_TESTS = 6;
    localparam int DIV_WRITES = 16;
    localparam int MAX_DIV = 15;
    // frames sent by the transmit, loopback, overrun, frame error and busy write tests.
    localparam int FRAME_COUNT = TX_TESTS + NUM_CHANNELS + 2 + 1 + 2;
    localparam int FRAME_CYCLES = FRAME_BITS * (MAX_DIV + 1);
    localparam int TIMEOUT_CYCLES = 2 * FRAME_COUNT * FRAME_CYCLES;

    logic clk;
    logic reset;
    logic sel;
    logic read;
    byte_mask_t write_mask;
    bus_addr_t address;
    bus_data_t write_value;
    bus_data_t read_value;
    chan_mask_t rx_in;
    chan_mask_t tx_out;
    chan_mask_t loop_mode;
    chan_mask_t line_drive;

    clk_div_t model_div [NUM_CHANNELS];
    uart_byte_t model_byte [NUM_CHANNELS];
    int cycle_count = 0;
    int check_count = 0;
    int error_count = 0;
    int test_errors = 0;
    int pass_count = 0;
    int fail_count = 0;
    string test_name;

    uart_subsystem dut (
        .clk(clk),
        .reset(reset),
        .sel(sel),
        .read(read),
        .write_mask(write_mask),
        .address(address),
        .write_value(write_value),
        .read_value(read_value),
        .rx_in(rx_in),
        .tx_out(tx_out)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // in loop mode receiver j listens to transmitter j - 1.
    always_comb begin
        for (int j = 0; j < NUM_CHANNELS; j++) begin
            rx_in[j] = loop_mode[j] ? tx_out[(j + NUM_CHANNELS - 1) % NUM_CHANNELS]
                                    : line_drive[j];
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic bus_addr_t reg_addr(int chan, reg_offset_t offset);
        bus_addr_t addr;
        addr = '0;
        addr[CHAN_ADDR_MSB:CHAN_ADDR_LSB] = 4'(chan);
        addr[3:2] = offset;
        return addr;
    endfunction

    function automatic clk_div_t merge_div(clk_div_t old, byte_mask_t mask, bus_data_t value);
        clk_div_t merged;
        merged = old;
        if (mask[0]) merged[7:0] = value[7:0];
        if (mask[1]) merged[15:8] = value[15:8];
        return merged;
    endfunction

    task automatic check_value(string label, bus_data_t expected, bus_data_t actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("FAILED %s (%s): expected 0x%08h, actual 0x%08h",
                     test_name, label, expected, actual);
        end
    endtask

    // bus tasks start and end 1 ns after a rising edge.
    task automatic bus_write(int chan, reg_offset_t offset, byte_mask_t mask, bus_data_t value);
        sel = 1'b1;
        address = reg_addr(chan, offset);
        write_mask = mask;
        write_value = value;
        @(posedge clk);
        #1;
        sel = 1'b0;
        write_mask = '0;
    endtask

    task automatic bus_read(int chan, reg_offset_t offset, logic consume, output bus_data_t value);
        sel = 1'b1;
        address = reg_addr(chan, offset);
        read = consume;
        #4;
        value = read_value;
        @(posedge clk);
        #1;
        sel = 1'b0;
        read = 1'b0;
    endtask

    task automatic expect_reg(string label, int chan, reg_offset_t offset, logic consume,
                              bus_data_t expected);
        bus_data_t value;
        bus_read(chan, offset, consume, value);
        check_value(label, expected, value);
    endtask

    task automatic wait_status(int chan, bus_data_t mask, bus_data_t want);
        bus_data_t value;
        int polls;
        polls = 0;
        bus_read(chan, REG_STATUS, 1'b0, value);
        while ((value & mask) != want && polls < 2 * FRAME_CYCLES) begin
            polls++;
            bus_read(chan, REG_STATUS, 1'b0, value);
        end
        if ((value & mask) != want) begin
            error_count++;
            $display("%s: channel %0d status never reached 0x%0h", test_name, chan, want);
        end
    endtask

    // bit k of a frame covers cycles k * (div + 1) up to (k + 1) * (div + 1) after the write.
    task automatic check_tx_frame(int chan, uart_byte_t data, logic second_write);
        int bit_cycles;
        int total;
        logic [FRAME_BITS-1:0] frame;
        bit_cycles = int'(model_div[chan]) + 1;
        total = FRAME_BITS * bit_cycles;
        frame = {1'b1, data, 1'b0};
        bus_write(chan, REG_DATA, 4'b0001, {24'b0, data});
        for (int c = 0; c <= total; c++) begin
            sel = 1'b1;
            address = reg_addr(chan, REG_STATUS);
            write_mask = '0;
            if (second_write && c == 2 * bit_cycles) begin
                address = reg_addr(chan, REG_DATA);
                write_mask = 4'b0001;
                write_value = {24'b0, ~data};
            end
            #4;
            if (c < total && c % bit_cycles == bit_cycles / 2) begin
                check_value("tx bit", 32'(frame[c / bit_cycles]), 32'(tx_out[chan]));
            end
            if (write_mask == '0) begin
                check_value("tx busy", 32'(c < total), 32'(read_value[0]));
            end
            @(posedge clk);
            #1;
        end
        sel = 1'b0;
        write_mask = '0;
    endtask

    task automatic drive_frame(int chan, uart_byte_t data, logic stop_bit);
        logic [FRAME_BITS-1:0] frame;
        frame = {stop_bit, data, 1'b0};
        for (int b = 0; b < FRAME_BITS; b++) begin
            line_drive[chan] = frame[b];
            repeat (int'(model_div[chan]) + 1) @(posedge clk);
            #1;
        end
        line_drive[chan] = 1'b1;
    endtask

    task automatic start_test(string name);
        test_name = name;
        test_errors = error_count;
    endtask

    task automatic end_test();
        if (error_count == test_errors) begin
            pass_count++;
            $display("test %s passed", test_name);
        end else begin
            fail_count++;
            $display("test %s failed with %0d errors", test_name, error_count - test_errors);
        end
    endtask

    initial begin
        int chan;
        int recv;
        byte_mask_t mask;
        bus_data_t value;
        clk_div_t div;
        uart_byte_t data;
        uart_byte_t second;
        chan_mask_t model_busy;
        chan_mask_t model_ready;

        void'($urandom(SEED));
        reset = 1'b1;
        sel = 1'b0;
        read = 1'b0;
        write_mask = '0;
        address = '0;
        write_value = '0;
        loop_mode = '0;
        line_drive = '1;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;

        start_test("divider_registers");
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            expect_reg("reset div", i, REG_CLK_DIV, 1'b0, 32'(DEFAULT_CLK_DIV));
            model_div[i] = DEFAULT_CLK_DIV;
        end
        for (int n = 0; n < DIV_WRITES; n++) begin
            chan = $urandom % NUM_CHANNELS;
            mask = 4'($urandom);
            value = $urandom;
            bus_write(chan, REG_CLK_DIV, mask, value);
            model_div[chan] = merge_div(model_div[chan], mask, value);
            expect_reg("div readback", chan, REG_CLK_DIV, 1'b0, 32'(model_div[chan]));
        end
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            expect_reg("unused offset", i, 2'd3, 1'b0, 32'h0);
        end
        // indices between the last channel and the summary page decode to nothing.
        for (int idx = NUM_CHANNELS; idx < int'(SUMMARY_PAGE); idx++) begin
            bus_write(idx, REG_CLK_DIV, 4'b1111, $urandom);
            expect_reg("unmapped index", idx, REG_CLK_DIV, 1'b0, 32'h0);
        end
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            expect_reg("div kept", i, REG_CLK_DIV, 1'b0, 32'(model_div[i]));
        end
        end_test();

        start_test("transmit_waveform");
        for (int t = 0; t < TX_TESTS; t++) begin
            chan = $urandom % NUM_CHANNELS;
            div = 16'($urandom % 8);
            bus_write(chan, REG_CLK_DIV, 4'b0011, 32'(div));
            model_div[chan] = div;
            check_tx_frame(chan, 8'($urandom), 1'b0);
        end
        end_test();

        start_test("loopback_receive");
        loop_mode = '1;
        div = 16'(4 + $urandom % (MAX_DIV - 3));
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            bus_write(i, REG_CLK_DIV, 4'b0011, 32'(div));
            model_div[i] = div;
        end
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            recv = (i + 1) % NUM_CHANNELS;
            data = 8'($urandom);
            model_byte[recv] = data;
            bus_write(i, REG_DATA, 4'b0001, 32'(data));
            wait_status(recv, 32'h2, 32'h2);
            expect_reg("rx ready", recv, REG_STATUS, 1'b0, 32'h2);
            expect_reg("rx byte", recv, REG_DATA, 1'b1, 32'(model_byte[recv]));
            expect_reg("ready cleared", recv, REG_STATUS, 1'b0, 32'h0);
            wait_status(i, 32'h1, 32'h0);
        end
        end_test();

        start_test("overrun_frame_error");
        data = 8'($urandom);
        second = ~data;
        model_byte[1] = data;
        bus_write(0, REG_DATA, 4'b0001, 32'(data));
        wait_status(1, 32'h2, 32'h2);
        wait_status(0, 32'h1, 32'h0);
        bus_write(0, REG_DATA, 4'b0001, 32'(second));
        wait_status(1, 32'h4, 32'h4);
        expect_reg("overrun status", 1, REG_STATUS, 1'b0, 32'h6);
        expect_reg("first byte kept", 1, REG_DATA, 1'b1, 32'(model_byte[1]));
        expect_reg("overrun cleared", 1, REG_STATUS, 1'b0, 32'h0);
        wait_status(0, 32'h1, 32'h0);
        loop_mode[2] = 1'b0;
        drive_frame(2, ~model_byte[2], 1'b0);
        wait_status(2, 32'h8, 32'h8);
        expect_reg("frame error status", 2, REG_STATUS, 1'b0, 32'h8);
        expect_reg("data after frame error", 2, REG_DATA, 1'b1, 32'(model_byte[2]));
        expect_reg("frame error cleared", 2, REG_STATUS, 1'b0, 32'h0);
        loop_mode[2] = 1'b1;
        end_test();

        start_test("busy_write_summary");
        data = 8'($urandom);
        second = 8'($urandom);
        model_byte[0] = data;
        model_byte[2] = second;
        check_tx_frame(3, data, 1'b1);
        wait_status(0, 32'h2, 32'h2);
        bus_write(1, REG_DATA, 4'b0001, 32'(second));
        model_busy = chan_mask_t'(1 << 1);
        model_ready = chan_mask_t'(1 << 0);
        expect_reg("summary busy", int'(SUMMARY_PAGE), REG_CLK_DIV, 1'b0,
                   32'({model_ready, model_busy}));
        wait_status(2, 32'h2, 32'h2);
        wait_status(1, 32'h1, 32'h0);
        model_busy = '0;
        model_ready = chan_mask_t'(5);
        expect_reg("summary idle", int'(SUMMARY_PAGE), REG_CLK_DIV, 1'b0,
                   32'({model_ready, model_busy}));
        expect_reg("first of two writes", 0, REG_DATA, 1'b1, 32'(model_byte[0]));
        expect_reg("second channel byte", 2, REG_DATA, 1'b1, 32'(model_byte[2]));
        expect_reg("summary cleared", int'(SUMMARY_PAGE), REG_CLK_DIV, 1'b0, 32'h0);
        end_test();

        $display("tests: %0d passed, %0d failed; checks: %0d, errors: %0d",
                 pass_count, fail_count, check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* verilog/uart_subsystem.sv */
`timescale 1ns/1ps

module uart_subsystem (
    input logic clk,
    input logic reset,

    input logic sel,
    input logic read,
    input uart_pkg::byte_mask_t write_mask,
    input uart_pkg::bus_addr_t address,
    input uart_pkg::bus_data_t write_value,
    output uart_pkg::bus_data_t read_value,

    input uart_pkg::chan_mask_t rx_in,
    output uart_pkg::chan_mask_t tx_out
);
    import uart_pkg::*;

    chan_mask_t chan_sel;
    reg_offset_t reg_offset;
    logic summary_sel;

    bus_data_t chan_read_values [NUM_CHANNELS];
    chan_mask_t tx_busy;
    chan_mask_t rx_ready;

    uart_bus_decode decode (
        .sel(sel),
        .address(address),
        .chan_sel(chan_sel),
        .reg_offset(reg_offset),
        .summary_sel(summary_sel)
    );

    for (genvar i = 0; i < NUM_CHANNELS; i++) begin : gen_chan
        uart_channel chan (
            .clk(clk),
            .reset(reset),
            .chan_sel(chan_sel[i]),
            .reg_offset(reg_offset),
            .read(read),
            .write_mask(write_mask),
            .write_value(write_value),
            .rx_in(rx_in[i]),
            .tx_out(tx_out[i]),
            .chan_read_value(chan_read_values[i]),
            .tx_busy(tx_busy[i]),
            .rx_ready(rx_ready[i])
        );
    end

    uart_read_collect collect (
        .summary_sel(summary_sel),
        .chan_read_values(chan_read_values),
        .tx_busy(tx_busy),
        .rx_ready(rx_ready),
        .read_value(read_value)
    );

endmodule

/* verilog/uart_read_collect.sv */
`timescale 1ns/1ps

module uart_read_collect (
    input logic summary_sel,
    input uart_pkg::bus_data_t chan_read_values [uart_pkg::NUM_CHANNELS],
    input uart_pkg::chan_mask_t tx_busy,
    input uart_pkg::chan_mask_t rx_ready,

    output uart_pkg::bus_data_t read_value
);
    import uart_pkg::*;

    bus_data_t chan_value;
    bus_data_t summary_value;

    // unselected channels return zero, so an OR is enough.
    always_comb begin
        chan_value = '0;
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            chan_value = chan_value | chan_read_values[i];
        end
    end

    always_comb begin
        summary_value = '0;
        if (summary_sel) begin
            summary_value[NUM_CHANNELS-1:0] = tx_busy;
            summary_value[2*NUM_CHANNELS-1:NUM_CHANNELS] = rx_ready;
        end
    end

    assign read_value = chan_value | summary_value;

endmodule

/* verilog/uart_bus_decode.sv */
`timescale 1ns/1ps

module uart_bus_decode (
    input logic sel,
    input uart_pkg::bus_addr_t address,

    output uart_pkg::chan_mask_t chan_sel,
    output uart_pkg::reg_offset_t reg_offset,
    output logic summary_sel
);
    import uart_pkg::*;

    chan_idx_t chan_idx;

    assign chan_idx = address[CHAN_ADDR_MSB:CHAN_ADDR_LSB];
    assign reg_offset = address[REG_ADDR_MSB:REG_ADDR_LSB];

    assign summary_sel = sel && (chan_idx == SUMMARY_PAGE);

    // indices past the last channel select nothing at all.
    always_comb begin
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            chan_sel[i] = sel && (chan_idx == chan_idx_t'(i));
        end
    end

endmodule

/* verilog/uart_channel.sv */
`timescale 1ns/1ps

module uart_channel (
    input logic clk,
    input logic reset,

    input logic chan_sel,
    input uart_pkg::reg_offset_t reg_offset,
    input logic read,
    input uart_pkg::byte_mask_t write_mask,
    input uart_pkg::bus_data_t write_value,

    input logic rx_in,
    output logic tx_out,

    output uart_pkg::bus_data_t chan_read_value,
    output logic tx_busy,
    output logic rx_ready
);
    import uart_pkg::*;

    clk_div_t clk_div;
    uart_byte_t rx_data;
    logic overrun;
    logic frame_err;

    logic tx_start;
    logic data_read;
    logic rx_load;

    logic rx_valid;
    uart_byte_t rx_byte;
    logic rx_frame_error;

    assign tx_start = chan_sel && (reg_offset == REG_DATA) && write_mask[0];
    assign data_read = chan_sel && read && (reg_offset == REG_DATA);

    // a byte that is read out in the same cycle makes room for the next one.
    assign rx_load = rx_valid && (!rx_ready || data_read);

    always_ff @(posedge clk) begin
        if (reset) begin
            clk_div <= DEFAULT_CLK_DIV;
        end else if (chan_sel && (reg_offset == REG_CLK_DIV)) begin
            if (write_mask[1]) begin
                clk_div[15:8] <= write_value[15:8];
            end
            if (write_mask[0]) begin
                clk_div[7:0] <= write_value[7:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rx_ready <= 1'b0;
            overrun <= 1'b0;
            frame_err <= 1'b0;
        end else begin
            if (data_read) begin
                rx_ready <= 1'b0;
                overrun <= 1'b0;
                frame_err <= 1'b0;
            end
            if (rx_load) begin
                rx_ready <= 1'b1;
            end else if (rx_valid) begin
                overrun <= 1'b1;
            end
            if (rx_frame_error) begin
                frame_err <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rx_load) begin
            rx_data <= rx_byte;
        end
    end

    always_comb begin
        chan_read_value = '0;
        if (chan_sel) begin
            case (reg_offset)
                REG_CLK_DIV: chan_read_value = {16'b0, clk_div};
                REG_STATUS: chan_read_value = {28'b0, frame_err, overrun, rx_ready, tx_busy};
                REG_DATA: chan_read_value = {24'b0, rx_data};
                default: chan_read_value = '0;
            endcase
        end
    end

    uart_tx tx (
        .clk(clk),
        .reset(reset),
        .clk_div(clk_div),
        .start(tx_start),
        .data(write_value[7:0]),
        .busy(tx_busy),
        .tx_out(tx_out)
    );

    uart_rx rx (
        .clk(clk),
        .reset(reset),
        .clk_div(clk_div),
        .rx_in(rx_in),
        .rx_valid(rx_valid),
        .rx_byte(rx_byte),
        .frame_error(rx_frame_error)
    );

endmodule

/* verilog/uart_rx.sv */
`timescale 1ns/1ps

module uart_rx (
    input logic clk,
    input logic reset,

    input uart_pkg::clk_div_t clk_div,

    input logic rx_in,

    output logic rx_valid,
    output uart_pkg::uart_byte_t rx_byte,
    output logic frame_error
);
    import uart_pkg::*;

    rx_state_t state;
    clk_div_t clks_left;
    logic [2:0] bit_idx;

    logic rx_meta;
    logic rx_sync;
    logic rx_last;
    logic rx_fall;

    // rx_in is asynchronous to clk.
    always_ff @(posedge clk) begin
        if (reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_last <= 1'b1;
        end else begin
            rx_meta <= rx_in;
            rx_sync <= rx_meta;
            rx_last <= rx_sync;
        end
    end

    assign rx_fall = rx_last && !rx_sync;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
            rx_valid <= 1'b0;
            frame_error <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            frame_error <= 1'b0;

            case (state)
                IDLE: begin
                    if (rx_fall) begin
                        // wait half a bit to land in the middle of the start bit.
                        clks_left <= clk_div >> 1;
                        state <= START;
                    end
                end
                START: begin
                    if (clks_left != '0) begin
                        clks_left <= clks_left - 1'b1;
                    end else if (!rx_sync) begin
                        clks_left <= clk_div;
                        bit_idx <= 3'd0;
                        state <= DATA;
                    end else begin
                        // a short glitch, not a start bit.
                        state <= IDLE;
                    end
                end
                DATA: begin
                    if (clks_left != '0) begin
                        clks_left <= clks_left - 1'b1;
                    end else begin
                        clks_left <= clk_div;
                        rx_byte <= {rx_sync, rx_byte[7:1]};
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= STOP;
                        end
                    end
                end
                STOP: begin
                    if (clks_left != '0) begin
                        clks_left <= clks_left - 1'b1;
                    end else begin
                        rx_valid <= rx_sync;
                        frame_error <= !rx_sync;
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

/* verilog/uart_tx.sv */
`timescale 1ns/1ps

module uart_tx (
    input logic clk,
    input logic reset,

    input uart_pkg::clk_div_t clk_div,

    input logic start,
    input uart_pkg::uart_byte_t data,

    output logic busy,
    output logic tx_out
);
    import uart_pkg::*;

    clk_div_t clks_left;
    logic [3:0] bits_left;
    logic [FRAME_BITS-1:0] shift_reg;

    assign busy = (bits_left != 4'd0);

    // the line always shows the low end of the shift register.
    assign tx_out = shift_reg[0];

    always_ff @(posedge clk) begin
        if (reset) begin
            bits_left <= 4'd0;
            shift_reg <= '1;
        end else begin
            if (start && !busy) begin
                clks_left <= clk_div;
                bits_left <= 4'(FRAME_BITS);
                shift_reg <= {1'b1, data, 1'b0};
            end else if (busy) begin
                if (clks_left != '0) begin
                    clks_left <= clks_left - 1'b1;
                end else begin
                    // ones shift in behind the frame, so the line idles high.
                    clks_left <= clk_div;
                    bits_left <= bits_left - 1'b1;
                    shift_reg <= {1'b1, shift_reg[FRAME_BITS-1:1]};
                end
            end
        end
    end

endmodule

/* verilog/uart_pkg.sv */
package uart_pkg;

    // channel count and address map.
    localparam int NUM_CHANNELS = 4;

    localparam int CHAN_ADDR_LSB = 4;
    localparam int CHAN_ADDR_MSB = 7;
    localparam int REG_ADDR_LSB = 2;
    localparam int REG_ADDR_MSB = 3;

    // one start bit, eight data bits and one stop bit.
    localparam int FRAME_BITS = 10;

    typedef logic [31:0] bus_addr_t;
    typedef logic [31:0] bus_data_t;
    typedef logic [3:0] byte_mask_t;
    typedef logic [1:0] reg_offset_t;
    typedef logic [CHAN_ADDR_MSB-CHAN_ADDR_LSB:0] chan_idx_t;

    // one bit lasts clk_div plus one clock cycles.
    typedef logic [15:0] clk_div_t;
    typedef logic [7:0] uart_byte_t;
    typedef logic [NUM_CHANNELS-1:0] chan_mask_t;

    // the last channel index is the summary status page.
    localparam chan_idx_t SUMMARY_PAGE = 4'd15;

    localparam reg_offset_t REG_CLK_DIV = 2'd0;
    localparam reg_offset_t REG_STATUS = 2'd1;
    localparam reg_offset_t REG_DATA = 2'd2;

    localparam clk_div_t DEFAULT_CLK_DIV = 16'd15;

    typedef enum logic [1:0] {
        IDLE,
        START,
        DATA,
        STOP
    } rx_state_t;

endpackage
